//--- source/pmp_settings.svh
// Region count, NAPOT granularity, address and index widths for the PMP unit
`ifndef PMP_SETTINGS_SVH
`define PMP_SETTINGS_SVH

// Number of implemented protection regions
`define PMP_NUM_REGIONS 4

// NAPOT granularity exponent
// 0 allows 4 byte regions, 1 gives 8 byte, 2 gives 16 byte and so on
`define PMP_GRANULARITY 0

// Width of a physical address as held in the region registers
`define PMP_ADDR_W 34

// Width of a region index, log2 of the region count
`define PMP_IDX_W 2

`endif

//--- source/pmp_pkg.sv
// PMP types: matching mode, access kind, privilege, region config, mseccfg, request, response
`default_nettype none
`include "pmp_settings.svh"

package pmp_pkg;

  // Address matching mode, encoded as in the pmpcfg A field
  typedef enum logic [1:0] {
    PMP_MODE_OFF   = 2'b00,
    PMP_MODE_TOR   = 2'b01,
    PMP_MODE_NA4   = 2'b10,
    PMP_MODE_NAPOT = 2'b11
  } pmp_mode_e;

  // Kind of access being checked
  typedef enum logic [1:0] {
    PMP_ACC_EXEC  = 2'b00,
    PMP_ACC_WRITE = 2'b01,
    PMP_ACC_READ  = 2'b10
  } pmp_acc_e;

  // Privilege level of the requester, S kept for encoding only
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // One region configuration byte, same bit layout as a pmpcfg field
  typedef struct packed {
    logic      lock;
    logic [1:0] rsvd;
    pmp_mode_e mode;
    logic      exec;
    logic      write;
    logic      read;
  } pmp_cfg_t;

  // Machine security configuration bits
  typedef struct packed {
    logic rlb;
    logic mmwp;
    logic mml;
  } pmp_mseccfg_t;

  // Access request as it travels down the pipeline
  typedef struct packed {
    logic [`PMP_ADDR_W-1:0] addr;
    pmp_acc_e               acc;
    priv_lvl_e              priv;
  } pmp_req_t;

  // Verdict returned with the address it belongs to
  typedef struct packed {
    logic [`PMP_ADDR_W-1:0] addr;
    logic                   err;
  } pmp_rsp_t;

endpackage

`default_nettype wire

//--- source/pmp_access_if.sv
// Interface between the request register and the checker, with src and chk modports
`default_nettype none
`timescale 1ns/1ns
`include "pmp_settings.svh"

interface pmp_access_if;
  import pmp_pkg::*;

  // Qualifies addr, acc, priv and err in the same cycle
  logic                   valid;
  logic [`PMP_ADDR_W-1:0] addr;
  pmp_acc_e               acc;
  priv_lvl_e              priv;
  // Access fault verdict, meaningful only while valid is high
  logic                   err;

  // Request side, filled from the registered request
  modport src (
    output valid, addr, acc, priv,
    input  err
  );

  // Checker side
  modport chk (
    input  valid, addr, acc, priv,
    output err
  );

endinterface

`default_nettype wire

//--- source/pmp_csr_regs.sv
// PMP register file: region config and address storage, lock rules, sticky mseccfg bits
`default_nettype none
`timescale 1ns/1ns
`include "pmp_settings.svh"

module pmp_csr_regs (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   cfg_we_i,
  input  logic [`PMP_IDX_W-1:0]  cfg_idx_i,
  input  pmp_pkg::pmp_cfg_t      cfg_wdata_i,
  input  logic [`PMP_ADDR_W-1:0] addr_wdata_i,
  input  logic                   mseccfg_we_i,
  input  pmp_pkg::pmp_mseccfg_t  mseccfg_wdata_i,
  output pmp_pkg::pmp_cfg_t      cfg_o [`PMP_NUM_REGIONS],
  output logic [`PMP_ADDR_W-1:0] addr_o [`PMP_NUM_REGIONS],
  output pmp_pkg::pmp_mseccfg_t  mseccfg_o
);
  import pmp_pkg::*;

  localparam int N     = `PMP_NUM_REGIONS;
  localparam int IDX_W = `PMP_IDX_W;

  pmp_cfg_t               cfg_q  [N];
  logic [`PMP_ADDR_W-1:0] addr_q [N];
  pmp_mseccfg_t           mseccfg_q;
  pmp_cfg_t               cfg_wr;
  // Entry refuses writes while this is set and rlb is clear
  logic [N-1:0]           entry_locked;
  logic [N-1:0]           entry_we;

  // Reserved config bits always read back as zero
  always_comb begin
    cfg_wr      = cfg_wdata_i;
    cfg_wr.rsvd = '0;
  end

  // ------------------------------------------------------------------------
  // Region entries
  // ------------------------------------------------------------------------
  for (genvar r = 0; r < N; r++) begin : g_entry
    // Locked by its own L bit, or by a locked TOR successor using it as base
    if (r == N - 1) begin : g_last
      assign entry_locked[r] = cfg_q[r].lock;
    end else begin : g_inner
      assign entry_locked[r] = cfg_q[r].lock ||
                               (cfg_q[r+1].lock && (cfg_q[r+1].mode == PMP_MODE_TOR));
    end

    // Rule locking bypass lets any entry be rewritten
    assign entry_we[r] = cfg_we_i && (cfg_idx_i == IDX_W'(r)) &&
                         (!entry_locked[r] || mseccfg_q.rlb);

    always_ff @(posedge clk) begin
      if (rst_i) begin
        cfg_q[r]  <= '0;
        addr_q[r] <= '0;
      end else if (entry_we[r]) begin
        cfg_q[r]  <= cfg_wr;
        addr_q[r] <= addr_wdata_i;
      end
    end
  end

  // ------------------------------------------------------------------------
  // Security configuration
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst_i) begin
      mseccfg_q <= '0;
    end else if (mseccfg_we_i) begin
      // mml and mmwp only ever set, cleared by reset alone
      mseccfg_q.mml  <= mseccfg_q.mml  | mseccfg_wdata_i.mml;
      mseccfg_q.mmwp <= mseccfg_q.mmwp | mseccfg_wdata_i.mmwp;
      mseccfg_q.rlb  <= mseccfg_wdata_i.rlb;
    end
  end

  assign cfg_o     = cfg_q;
  assign addr_o    = addr_q;
  assign mseccfg_o = mseccfg_q;

endmodule

`default_nettype wire

//--- source/pmp_pipe_reg.sv
// Pipeline register with a resettable valid flag and a typed payload
`default_nettype none
`timescale 1ns/1ns

module pmp_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  // Valid flag, cleared by reset
  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // Payload loads only with a valid beat
  // Data holds its last value through idle cycles
  always_ff @(posedge clk) begin
    if (valid_i) begin
      data_o <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- source/pmp_checker.sv
// PMP access checker: per-region matching, R/W/X and MML permission checks, priority
`default_nettype none
`timescale 1ns/1ns
`include "pmp_settings.svh"

module pmp_checker (
  pmp_access_if.chk              acc,
  input pmp_pkg::pmp_cfg_t       cfg_i  [`PMP_NUM_REGIONS],
  input logic [`PMP_ADDR_W-1:0]  addr_i [`PMP_NUM_REGIONS],
  input pmp_pkg::pmp_mseccfg_t   mseccfg_i
);
  import pmp_pkg::*;

  localparam int N  = `PMP_NUM_REGIONS;
  localparam int AW = `PMP_ADDR_W;
  localparam int G  = `PMP_GRANULARITY;
  // Lowest address bit that takes part in any comparison
  localparam int CMP_LSB  = G + 2;
  // Lowest bit of the trailing ones run that encodes the NAPOT size
  localparam int ONES_LSB = (G == 0) ? 2 : G + 1;

  logic [AW-1:0]       start_addr [N];
  logic [AW-1:CMP_LSB] napot_mask [N];
  logic [N-1:0]        match_eq;
  logic [N-1:0]        match_gt;
  logic [N-1:0]        match_lt;
  logic [N-1:0]        match;
  logic [N-1:0]        basic_ok;
  logic [N-1:0]        mml_ok;
  logic                access_fault;

  // Region hit for the given mode from the three comparisons
  function automatic logic mode_match(pmp_mode_e mode, logic eq, logic gt, logic lt);
    case (mode)
      PMP_MODE_TOR:                 mode_match = (eq || gt) && lt;
      PMP_MODE_NA4, PMP_MODE_NAPOT: mode_match = eq;
      default:                      mode_match = 1'b0;
    endcase
  endfunction

  // Plain R/W/X lookup for the access kind
  function automatic logic basic_perm(pmp_cfg_t cfg, pmp_acc_e kind);
    case (kind)
      PMP_ACC_READ:  basic_perm = cfg.read;
      PMP_ACC_WRITE: basic_perm = cfg.write;
      PMP_ACC_EXEC:  basic_perm = cfg.exec;
      default:       basic_perm = 1'b0;
    endcase
  endfunction

  // Permission table that applies once mml is set
  function automatic logic mml_perm(pmp_cfg_t cfg, pmp_acc_e kind, priv_lvl_e priv,
                                    logic basic);
    logic is_m;
    is_m = (priv == PRIV_LVL_M);
    if (!cfg.read && cfg.write) begin
      // Shared regions, selected by L and X
      case ({cfg.lock, cfg.exec})
        2'b00:   mml_perm = (kind == PMP_ACC_READ) || ((kind == PMP_ACC_WRITE) && is_m);
        2'b01:   mml_perm = (kind == PMP_ACC_READ) || (kind == PMP_ACC_WRITE);
        2'b10:   mml_perm = (kind == PMP_ACC_EXEC);
        default: mml_perm = (kind == PMP_ACC_EXEC) || ((kind == PMP_ACC_READ) && is_m);
      endcase
    end else if (cfg.lock && cfg.read && cfg.write && cfg.exec) begin
      // Read only for every privilege
      mml_perm = (kind == PMP_ACC_READ);
    end else begin
      // Locked entries serve M only, unlocked entries serve S and U only
      mml_perm = basic && (is_m ? cfg.lock : !cfg.lock);
    end
  endfunction

  // ------------------------------------------------------------------------
  // Per-region matching and permissions
  // ------------------------------------------------------------------------
  for (genvar r = 0; r < N; r++) begin : g_region
    // TOR base is the previous entry, or zero for entry 0
    if (r == 0) begin : g_first
      assign start_addr[r] = (cfg_i[r].mode == PMP_MODE_TOR) ? '0 : addr_i[r];
    end else begin : g_next
      assign start_addr[r] = (cfg_i[r].mode == PMP_MODE_TOR) ? addr_i[r-1] : addr_i[r];
    end

    // NAPOT mask drops bit 2 and every bit up to the first zero
    for (genvar b = CMP_LSB; b < AW; b++) begin : g_mask
      if (b == 2) begin : g_low
        assign napot_mask[r][b] = (cfg_i[r].mode != PMP_MODE_NAPOT);
      end else begin : g_high
        assign napot_mask[r][b] = (cfg_i[r].mode != PMP_MODE_NAPOT) ||
                                  !(&addr_i[r][b-1:ONES_LSB]);
      end
    end

    // Comparators only cover bits above the granule
    assign match_eq[r] = (acc.addr[AW-1:CMP_LSB] & napot_mask[r]) ==
                         (start_addr[r][AW-1:CMP_LSB] & napot_mask[r]);
    assign match_gt[r] = acc.addr[AW-1:CMP_LSB] > start_addr[r][AW-1:CMP_LSB];
    assign match_lt[r] = acc.addr[AW-1:CMP_LSB] < addr_i[r][AW-1:CMP_LSB];

    assign match[r]    = mode_match(cfg_i[r].mode, match_eq[r], match_gt[r], match_lt[r]);
    assign basic_ok[r] = basic_perm(cfg_i[r], acc.acc);
    assign mml_ok[r]   = mml_perm(cfg_i[r], acc.acc, acc.priv, basic_ok[r]);
  end

  // ------------------------------------------------------------------------
  // Verdict
  // ------------------------------------------------------------------------
  always_comb begin
    // No match: deny under mmwp or below M, allow M otherwise
    access_fault = mseccfg_i.mmwp || (acc.priv != PRIV_LVL_M);
    // Walk downward so the lowest matching index wins
    for (int r = N - 1; r >= 0; r--) begin
      if (match[r]) begin
        if (mseccfg_i.mml) begin
          access_fault = !mml_ok[r];
        end else if (acc.priv == PRIV_LVL_M) begin
          // M only trips on a locked entry
          access_fault = cfg_i[r].lock && !basic_ok[r];
        end else begin
          access_fault = !basic_ok[r];
        end
      end
    end
  end

  assign acc.err = acc.valid && access_fault;

endmodule

`default_nettype wire

//--- source/pmp_unit_top.sv
// PMP unit top level with register file, request and response stages and checker
`default_nettype none
`timescale 1ns/1ns
`include "pmp_settings.svh"

module pmp_unit_top (
  input  logic                   clk,
  input  logic                   rst_i,
  // Register writes
  input  logic                   cfg_we_i,
  input  logic [`PMP_IDX_W-1:0]  cfg_idx_i,
  input  pmp_pkg::pmp_cfg_t      cfg_wdata_i,
  input  logic [`PMP_ADDR_W-1:0] addr_wdata_i,
  input  logic                   mseccfg_we_i,
  input  pmp_pkg::pmp_mseccfg_t  mseccfg_wdata_i,
  // Requests
  input  logic                   req_valid_i,
  input  logic [`PMP_ADDR_W-1:0] req_addr_i,
  input  pmp_pkg::pmp_acc_e      req_acc_i,
  input  pmp_pkg::priv_lvl_e     req_priv_i,
  // Responses two cycles after the request
  output logic                   rsp_valid_o,
  output logic [`PMP_ADDR_W-1:0] rsp_addr_o,
  output logic                   rsp_err_o
);
  import pmp_pkg::*;

  pmp_cfg_t               cfg     [`PMP_NUM_REGIONS];
  logic [`PMP_ADDR_W-1:0] addr    [`PMP_NUM_REGIONS];
  pmp_mseccfg_t           mseccfg;
  pmp_req_t               req_d;
  pmp_req_t               req_q;
  logic                   req_q_valid;
  pmp_rsp_t               rsp_d;
  pmp_rsp_t               rsp_q;

  pmp_access_if acc_if ();

  pmp_csr_regs csr_regs (
    .clk             (clk),
    .rst_i           (rst_i),
    .cfg_we_i        (cfg_we_i),
    .cfg_idx_i       (cfg_idx_i),
    .cfg_wdata_i     (cfg_wdata_i),
    .addr_wdata_i    (addr_wdata_i),
    .mseccfg_we_i    (mseccfg_we_i),
    .mseccfg_wdata_i (mseccfg_wdata_i),
    .cfg_o           (cfg),
    .addr_o          (addr),
    .mseccfg_o       (mseccfg)
  );

  // ------------------------------------------------------------------------
  // Request stage
  // ------------------------------------------------------------------------
  assign req_d = '{addr: req_addr_i, acc: req_acc_i, priv: req_priv_i};

  pmp_pipe_reg #(.payload_t(pmp_req_t)) req_stage (
    .clk     (clk),
    .rst_i   (rst_i),
    .valid_i (req_valid_i),
    .data_i  (req_d),
    .valid_o (req_q_valid),
    .data_o  (req_q)
  );

  // Registered request onto the checker interface
  assign acc_if.valid = req_q_valid;
  assign acc_if.addr  = req_q.addr;
  assign acc_if.acc   = req_q.acc;
  assign acc_if.priv  = req_q.priv;

  pmp_checker access_checker (
    .acc       (acc_if),
    .cfg_i     (cfg),
    .addr_i    (addr),
    .mseccfg_i (mseccfg)
  );

  // ------------------------------------------------------------------------
  // Response stage
  // ------------------------------------------------------------------------
  assign rsp_d = '{addr: acc_if.addr, err: acc_if.err};

  pmp_pipe_reg #(.payload_t(pmp_rsp_t)) rsp_stage (
    .clk     (clk),
    .rst_i   (rst_i),
    .valid_i (acc_if.valid),
    .data_i  (rsp_d),
    .valid_o (rsp_valid_o),
    .data_o  (rsp_q)
  );

  assign rsp_addr_o = rsp_q.addr;
  assign rsp_err_o  = rsp_q.err;

endmodule

`default_nettype wire

//--- dv/pmp_unit_assertions.sv
// Concurrent assertions on response latency, reset behavior and sticky mseccfg bits
`default_nettype none
`timescale 1ns/1ns

module pmp_unit_assertions (
  input logic                  clk,
  input logic                  rst_i,
  input logic                  req_valid_i,
  input logic                  rsp_valid_o,
  input pmp_pkg::pmp_mseccfg_t mseccfg_i
);
  import pmp_pkg::*;

  // Every request comes back exactly two cycles later
  a_rsp_latency: assert property (@(posedge clk) disable iff (rst_i)
    req_valid_i |-> ##2 rsp_valid_o)
    else $error("response missing two cycles after request");

  // No response without a request two cycles earlier
  a_rsp_source: assert property (@(posedge clk) disable iff (rst_i)
    rsp_valid_o |-> $past(req_valid_i, 2))
    else $error("response without matching request");

  // Pipeline stays empty through reset
  a_rsp_reset: assert property (@(posedge clk) rst_i |=> !rsp_valid_o)
    else $error("response valid during or right after reset");

  // mml and mmwp only clear through reset
  a_mml_sticky: assert property (@(posedge clk) disable iff (rst_i) !$fell(mseccfg_i.mml))
    else $error("mml cleared outside reset");
  a_mmwp_sticky: assert property (@(posedge clk) disable iff (rst_i) !$fell(mseccfg_i.mmwp))
    else $error("mmwp cleared outside reset");

endmodule

`default_nettype wire

//--- dv/pmp_unit_tb.sv
// PMP unit testbench with stimulus table, response queue and typed compare tasks
`default_nettype none
`timescale 1ns/1ns
`include "pmp_settings.svh"

module pmp_unit_tb;
  import pmp_pkg::*;

  localparam int K_CFG  = 0;
  localparam int K_MSEC = 1;
  localparam int K_REQ  = 2;
  localparam int K_RAND = 3;

  typedef struct packed {
    int                     kind;
    logic [`PMP_IDX_W-1:0]  idx;
    pmp_cfg_t               cfg;
    logic [`PMP_ADDR_W-1:0] addr;
    pmp_mseccfg_t           msec;
    pmp_acc_e               acc;
    priv_lvl_e              priv;
    logic                   err;
  } step_t;

  logic                   clk;
  logic                   rst_i;
  logic                   cfg_we_i;
  logic [`PMP_IDX_W-1:0]  cfg_idx_i;
  pmp_cfg_t               cfg_wdata_i;
  logic [`PMP_ADDR_W-1:0] addr_wdata_i;
  logic                   mseccfg_we_i;
  pmp_mseccfg_t           mseccfg_wdata_i;
  logic                   req_valid_i;
  logic [`PMP_ADDR_W-1:0] req_addr_i;
  pmp_acc_e               req_acc_i;
  priv_lvl_e              req_priv_i;
  logic                   rsp_valid_o;
  logic [`PMP_ADDR_W-1:0] rsp_addr_o;
  logic                   rsp_err_o;

  step_t    steps[$];
  string    step_names[$];
  pmp_rsp_t exp_rsp[$];
  int       exp_cyc[$];
  string    exp_name[$];
  int       cyc;
  int       cyc_limit;
  int       n_tests;
  int       n_errors;
  integer   seed;

  pmp_unit_top dut0 (.*);

  bind pmp_unit_top pmp_unit_assertions asrt0 (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .rsp_valid_o (rsp_valid_o),
    .mseccfg_i   (mseccfg)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------------------------------------------------
  // Table building
  // ------------------------------------------------------------------------
  function automatic pmp_cfg_t make_cfg(logic l, pmp_mode_e m, logic x, logic w, logic r);
    pmp_cfg_t c;
    c = '0;
    c.lock  = l;
    c.mode  = m;
    c.exec  = x;
    c.write = w;
    c.read  = r;
    return c;
  endfunction

  task automatic add_cfg(int idx, pmp_cfg_t c, logic [`PMP_ADDR_W-1:0] a);
    step_t s;
    s      = '0;
    s.kind = K_CFG;
    s.idx  = idx[`PMP_IDX_W-1:0];
    s.cfg  = c;
    s.addr = a;
    steps.push_back(s);
    step_names.push_back("cfg write");
  endtask

  task automatic add_msec(logic rlb, logic mmwp, logic mml);
    step_t s;
    s      = '0;
    s.kind = K_MSEC;
    s.msec = '{rlb: rlb, mmwp: mmwp, mml: mml};
    steps.push_back(s);
    step_names.push_back("mseccfg write");
  endtask

  task automatic add_req(int kind, logic [`PMP_ADDR_W-1:0] a, pmp_acc_e k, priv_lvl_e p,
                         logic e, string name);
    step_t s;
    s      = '0;
    s.kind = kind;
    s.addr = a;
    s.acc  = k;
    s.priv = p;
    s.err  = e;
    steps.push_back(s);
    step_names.push_back(name);
  endtask

  task automatic build_table();
    // Defaults with no region configured
    add_req(K_REQ, 34'h50, PMP_ACC_READ, PRIV_LVL_M, 1'b0, "reset M read allowed");
    add_req(K_REQ, 34'h50, PMP_ACC_READ, PRIV_LVL_U, 1'b1, "reset U read faults");
    // NA4 R at 0x100, NAPOT RW over 0x200-0x207, TOR X over 0x300-0x33f
    add_cfg(0, make_cfg(0, PMP_MODE_NA4, 0, 0, 1), 34'h100);
    add_cfg(1, make_cfg(0, PMP_MODE_NAPOT, 0, 1, 1), 34'h203);
    add_cfg(2, make_cfg(0, PMP_MODE_OFF, 0, 0, 0), 34'h300);
    add_cfg(3, make_cfg(0, PMP_MODE_TOR, 1, 0, 0), 34'h340);
    add_req(K_REQ, 34'h100, PMP_ACC_READ, PRIV_LVL_U, 1'b0, "NA4 U read");
    add_req(K_REQ, 34'h100, PMP_ACC_WRITE, PRIV_LVL_U, 1'b1, "NA4 U write");
    add_req(K_REQ, 34'h204, PMP_ACC_WRITE, PRIV_LVL_U, 1'b0, "NAPOT U write");
    add_req(K_REQ, 34'h204, PMP_ACC_EXEC, PRIV_LVL_U, 1'b1, "NAPOT U exec");
    add_req(K_REQ, 34'h310, PMP_ACC_EXEC, PRIV_LVL_U, 1'b0, "TOR U exec");
    add_req(K_REQ, 34'h310, PMP_ACC_READ, PRIV_LVL_U, 1'b1, "TOR U read");
    add_req(K_REQ, 34'h208, PMP_ACC_READ, PRIV_LVL_U, 1'b1, "outside U read");
    for (int i = 0; i < 4; i++) begin
      add_req(K_RAND, '0, PMP_ACC_READ, PRIV_LVL_U, 1'b1, "random outside U read");
    end
    // Region 0 without permissions overlaps the TOR region
    add_cfg(0, make_cfg(0, PMP_MODE_NA4, 0, 0, 0), 34'h300);
    add_req(K_REQ, 34'h300, PMP_ACC_EXEC, PRIV_LVL_U, 1'b1, "overlap lower index wins");
    add_req(K_REQ, 34'h310, PMP_ACC_EXEC, PRIV_LVL_U, 1'b0, "overlap outside region 0");
    // Lock semantics for M-mode
    add_req(K_REQ, 34'h300, PMP_ACC_READ, PRIV_LVL_M, 1'b0, "M on unlocked region");
    add_cfg(0, make_cfg(1, PMP_MODE_NA4, 0, 0, 0), 34'h300);
    add_req(K_REQ, 34'h300, PMP_ACC_READ, PRIV_LVL_M, 1'b1, "M on locked region");
    add_cfg(0, make_cfg(0, PMP_MODE_NA4, 0, 0, 1), 34'h300);
    add_req(K_REQ, 34'h300, PMP_ACC_READ, PRIV_LVL_M, 1'b1, "locked write dropped");
    add_msec(1, 0, 0);
    add_cfg(0, make_cfg(0, PMP_MODE_NA4, 0, 0, 1), 34'h300);
    add_req(K_REQ, 34'h300, PMP_ACC_READ, PRIV_LVL_M, 1'b0, "rlb write taken M");
    add_req(K_REQ, 34'h300, PMP_ACC_READ, PRIV_LVL_U, 1'b0, "rlb write taken U");
    add_msec(0, 0, 0);
    // mmwp denies M outside all regions
    add_msec(0, 1, 0);
    add_req(K_REQ, 34'h4000, PMP_ACC_READ, PRIV_LVL_M, 1'b1, "mmwp M outside");
    add_req(K_REQ, 34'h204, PMP_ACC_READ, PRIV_LVL_M, 1'b0, "mmwp M inside");
    // mml shared region with unlocked W only
    add_msec(0, 0, 1);
    add_cfg(1, make_cfg(0, PMP_MODE_NAPOT, 0, 1, 0), 34'h203);
    add_req(K_REQ, 34'h204, PMP_ACC_WRITE, PRIV_LVL_U, 1'b1, "mml shared00 U write");
    add_req(K_REQ, 34'h204, PMP_ACC_WRITE, PRIV_LVL_M, 1'b0, "mml shared00 M write");
    add_req(K_REQ, 34'h204, PMP_ACC_READ, PRIV_LVL_U, 1'b0, "mml shared00 U read");
    add_req(K_REQ, 34'h204, PMP_ACC_EXEC, PRIV_LVL_U, 1'b1, "mml shared00 U exec");
    // Locked shared code region with W and X
    add_cfg(1, make_cfg(1, PMP_MODE_NAPOT, 1, 1, 0), 34'h203);
    add_req(K_REQ, 34'h204, PMP_ACC_READ, PRIV_LVL_M, 1'b0, "mml shared11 M read");
    add_req(K_REQ, 34'h204, PMP_ACC_READ, PRIV_LVL_U, 1'b1, "mml shared11 U read");
    add_req(K_REQ, 34'h204, PMP_ACC_EXEC, PRIV_LVL_U, 1'b0, "mml shared11 U exec");
    add_req(K_REQ, 34'h204, PMP_ACC_WRITE, PRIV_LVL_M, 1'b1, "mml shared11 M write");
    // Clearing attempt leaves mml and mmwp set
    add_msec(0, 0, 0);
    add_req(K_REQ, 34'h4000, PMP_ACC_READ, PRIV_LVL_M, 1'b1, "mmwp kept");
    add_req(K_REQ, 34'h204, PMP_ACC_READ, PRIV_LVL_M, 1'b0, "mml kept");
    // Back to back burst with address and type changing every cycle
    add_req(K_REQ, 34'h300, PMP_ACC_READ, PRIV_LVL_U, 1'b0, "burst 0");
    add_req(K_REQ, 34'h204, PMP_ACC_EXEC, PRIV_LVL_U, 1'b0, "burst 1");
    add_req(K_REQ, 34'h320, PMP_ACC_WRITE, PRIV_LVL_U, 1'b1, "burst 2");
    add_req(K_REQ, 34'h5000, PMP_ACC_EXEC, PRIV_LVL_M, 1'b1, "burst 3");
  endtask

  // ------------------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------------------
  task automatic check_valid(logic got, logic exp);
    if (got !== exp) begin
      $display("error t=%0t rsp_valid_o got %0b exp %0b", $time, got, exp);
      n_errors++;
    end
  endtask

  task automatic check_rsp(pmp_rsp_t got, pmp_rsp_t exp, string name);
    bit ok;
    ok = 1'b1;
    if (got.addr !== exp.addr) begin
      $display("error t=%0t rsp_addr_o got %h exp %h", $time, got.addr, exp.addr);
      ok = 1'b0;
    end
    if (got.err !== exp.err) begin
      $display("error t=%0t rsp_err_o got %0b exp %0b", $time, got.err, exp.err);
      ok = 1'b0;
    end
    n_tests++;
    if (ok) begin
      $display("pass %s", name);
    end else begin
      $display("fail %s", name);
      n_errors++;
    end
  endtask

  // Sample responses half a cycle after the edge, where they are stable
  always @(negedge clk) begin
    logic exp_v;
    if (!rst_i) begin
      exp_v = (exp_cyc.size() > 0) && (exp_cyc[0] == cyc);
      check_valid(rsp_valid_o, exp_v);
      if (exp_v) begin
        check_rsp('{addr: rsp_addr_o, err: rsp_err_o}, exp_rsp.pop_front(),
                  exp_name.pop_front());
        void'(exp_cyc.pop_front());
      end
    end
  end

  // Cycle counter and run limit
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= cyc_limit) begin
      $display("timeout after %0d cycles with %0d responses outstanding", cyc, exp_rsp.size());
      $display("TB FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------
  initial begin
    logic [31:0] rnd;
    logic [`PMP_ADDR_W-1:0] a;
    rst_i           = 1'b1;
    cfg_we_i        = 1'b0;
    cfg_idx_i       = '0;
    cfg_wdata_i     = '0;
    addr_wdata_i    = '0;
    mseccfg_we_i    = 1'b0;
    mseccfg_wdata_i = '0;
    req_valid_i     = 1'b0;
    req_addr_i      = '0;
    req_acc_i       = PMP_ACC_READ;
    req_priv_i      = PRIV_LVL_M;
    cyc             = 0;
    n_tests         = 0;
    n_errors        = 0;
    seed            = 2;
    build_table();
    cyc_limit = 2 * steps.size() + 50;
    repeat (10) @(posedge clk);
    rst_i <= 1'b0;
    foreach (steps[i]) begin
      @(posedge clk);
      a = steps[i].addr;
      if (steps[i].kind == K_RAND) begin
        // Random word address in 0x4000-0x4fff far from every region
        rnd = $random(seed);
        a   = 34'h4000 | {22'b0, rnd[11:0]};
      end
      cfg_we_i        <= (steps[i].kind == K_CFG);
      cfg_idx_i       <= steps[i].idx;
      cfg_wdata_i     <= steps[i].cfg;
      addr_wdata_i    <= a;
      mseccfg_we_i    <= (steps[i].kind == K_MSEC);
      mseccfg_wdata_i <= steps[i].msec;
      req_valid_i     <= (steps[i].kind == K_REQ) || (steps[i].kind == K_RAND);
      req_addr_i      <= a;
      req_acc_i       <= steps[i].acc;
      req_priv_i      <= steps[i].priv;
      if ((steps[i].kind == K_REQ) || (steps[i].kind == K_RAND)) begin
        exp_rsp.push_back('{addr: a, err: steps[i].err});
        // Sampled by the DUT one edge later, visible after the edge after that
        exp_cyc.push_back(cyc + 3);
        exp_name.push_back(step_names[i]);
      end
    end
    @(posedge clk);
    cfg_we_i     <= 1'b0;
    mseccfg_we_i <= 1'b0;
    req_valid_i  <= 1'b0;
    while (exp_rsp.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    $display("tests %0d errors %0d", n_tests, n_errors);
    if (n_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+source
source/pmp_pkg.sv
source/pmp_access_if.sv
source/pmp_csr_regs.sv
source/pmp_pipe_reg.sv
source/pmp_checker.sv
source/pmp_unit_top.sv
dv/pmp_unit_assertions.sv
dv/pmp_unit_tb.sv

//--- Makefile
SIM      = verilator
SIMFLAGS = --binary --assert --timing
TOP      = pmp_unit_tb
FLIST    = build.f
LOG      = sim.log

SRCS = $(shell grep -v '^+' $(FLIST)) source/pmp_settings.svh
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
